// File: logic/tenyr_pkg.sv
package tenyr_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [3:0]  reg_idx_t; // Register index
    typedef logic [11:0] imm_t;     // Signed immediate field
    typedef logic [3:0]  alu_op_t;  // Operation code
    typedef logic [1:0]  deref_t;   // Deref mode

    // Field order follows the bit layout of the instruction word, 30 down to 0
    typedef struct packed {
        logic     itype; // 0: O is Y, A is imm; 1: O is imm, A is Y
        deref_t   deref;
        reg_idx_t z;
        reg_idx_t x;
        reg_idx_t y;
        alu_op_t  op;
        imm_t     imm;
    } insn_fields_t;

    // One memory request, held as a level by its requester
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef enum logic [2:0] {
        S_FETCH,      // Instruction request
        S_FETCH_WAIT, // Instruction word on its way back
        S_EXEC,       // Decode and ALU
        S_MEM,        // Load or store request
        S_MEM_WAIT,   // Load data on its way back
        S_WRITE,      // Register write and PC update
        S_HALT
    } core_state_e;

    localparam reg_idx_t REG_P        = 4'd15;
    localparam word_t    RESET_VECTOR = 32'd0;

    // Deref encodings
    //   00  Z  <-  result
    //   01  Z  <- [result]
    //   10 [Z] <-  result
    //   11 [result] <- Z
    localparam deref_t DEREF_REG   = 2'b00;
    localparam deref_t DEREF_LOAD  = 2'b01;
    localparam deref_t DEREF_ST_Z  = 2'b10;
    localparam deref_t DEREF_ST_RS = 2'b11;

endpackage

// File: logic/insn_decode.sv
module insn_decode (
    input  tenyr_pkg::word_t        i_insn,
    output tenyr_pkg::insn_fields_t o_fields,
    output logic                    o_illegal,
    output logic                    o_nop
);

    import tenyr_pkg::*;

    logic top_ones; // Top nibble all ones

    // Fields are split out for any word; the flags decide whether they count
    always_comb begin
        o_fields.itype = i_insn[30];
        o_fields.deref = deref_t'(i_insn[29:28]);
        o_fields.z     = reg_idx_t'(i_insn[27:24]);
        o_fields.x     = reg_idx_t'(i_insn[23:20]);
        o_fields.y     = reg_idx_t'(i_insn[19:16]);
        o_fields.op    = alu_op_t'(i_insn[15:12]);
        o_fields.imm   = imm_t'(i_insn[11:0]);
    end

    assign top_ones = &i_insn[31:28];

    // Halting word
    assign o_illegal = top_ones;

    // Bit 31 set without the halt pattern does nothing
    assign o_nop = i_insn[31] && !top_ones;

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               reset_n,
    input  tenyr_pkg::reg_idx_t i_x_idx,
    input  tenyr_pkg::reg_idx_t i_y_idx,
    input  tenyr_pkg::reg_idx_t i_z_idx,
    input  tenyr_pkg::word_t   i_p_value,
    output tenyr_pkg::word_t   o_x,
    output tenyr_pkg::word_t   o_y,
    output tenyr_pkg::word_t   o_z,
    input  logic               i_we,
    input  tenyr_pkg::word_t   i_wdata
);

    import tenyr_pkg::*;

    // Only r1..r14 hold state, r0 and P are supplied here
    word_t regs [1:14];

    function automatic word_t read_reg(input reg_idx_t idx, input word_t stored,
                                       input word_t p_value);
        word_t value;
        if (idx == '0)
            value = '0;
        else if (idx == REG_P)
            value = p_value; // Address of the instruction plus one
        else
            value = stored;
        return value;
    endfunction

    assign o_x = read_reg(i_x_idx, regs[i_x_idx], i_p_value);
    assign o_y = read_reg(i_y_idx, regs[i_y_idx], i_p_value);
    assign o_z = read_reg(i_z_idx, regs[i_z_idx], i_p_value);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 1; i <= 14; i++)
                regs[i] <= '0;
        end else if (i_we && i_z_idx != '0 && i_z_idx != REG_P) begin
            regs[i_z_idx] <= i_wdata;
        end
    end

endmodule

// File: logic/alu_exec.sv
module alu_exec (
    input  tenyr_pkg::insn_fields_t i_fields,
    input  tenyr_pkg::word_t        i_x,
    input  tenyr_pkg::word_t        i_y,
    output tenyr_pkg::word_t        o_result
);

    import tenyr_pkg::*;

    word_t imm_ext; // Sign-extended immediate
    word_t o_val;   // Right operand of the op
    word_t a_val;   // Addend
    word_t op_val;  // X op O
    logic  shift_out;

    assign imm_ext = {{20{i_fields.imm[11]}}, i_fields.imm};

    assign o_val = i_fields.itype ? imm_ext : i_y;
    assign a_val = i_fields.itype ? i_y : imm_ext;

    // Shift amounts of 32 and up push every bit out
    assign shift_out = (o_val >= 32'd32);

    always_comb begin
        case (i_fields.op)
            4'b0000: op_val = i_x | o_val;
            4'b0001: op_val = i_x & o_val;
            4'b0010: op_val = i_x + o_val;
            4'b0011: op_val = i_x * o_val; // Low 32 bits of the product
            4'b0101: op_val = shift_out ? '0 : (i_x << o_val[4:0]);
            4'b0110: op_val = {32{$signed(i_x) < $signed(o_val)}};
            4'b0111: op_val = {32{i_x == o_val}};
            4'b1000: op_val = {32{$signed(i_x) > $signed(o_val)}};
            4'b1001: op_val = i_x & ~o_val;
            4'b1010: op_val = i_x ^ o_val;
            4'b1011: op_val = i_x - o_val;
            4'b1100: op_val = i_x ^ ~o_val;
            4'b1101: op_val = shift_out ? '0 : (i_x >> o_val[4:0]);
            4'b1110: op_val = {32{i_x != o_val}}; // All ones like the others
            default: op_val = '0; // Reserved 0100 and 1111, result is A alone
        endcase
    end

    assign o_result = op_val + a_val;

endmodule

// File: logic/core_control.sv
module core_control #(
    parameter int ADDR_W = 10
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 i_run,
    output logic                 o_req,
    output tenyr_pkg::bus_req_t  o_bus,
    input  logic                 i_grant,
    input  logic                 i_rvalid,
    input  tenyr_pkg::word_t     i_rdata,
    output logic                 o_halt,
    output logic                 o_retire
);

    import tenyr_pkg::*;

    localparam word_t ADDR_MASK = word_t'((64'd1 << ADDR_W) - 64'd1);

    core_state_e  state_q, state_d;
    word_t        pc_q;
    word_t        insn_q;   // Fetched instruction
    word_t        result_q; // ALU result
    word_t        load_q;   // Loaded data
    logic         halt_q;

    insn_fields_t fields;
    logic         illegal, nop;
    word_t        x_val, y_val, z_val;
    word_t        alu_result;
    word_t        wb_value;
    logic         wb_reg;  // Instruction writes Z
    logic         jump;    // Z is P

    insn_decode u_decode (
        .i_insn    (insn_q),
        .o_fields  (fields),
        .o_illegal (illegal),
        .o_nop     (nop)
    );

    reg_file u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_x_idx   (fields.x),
        .i_y_idx   (fields.y),
        .i_z_idx   (fields.z),
        .i_p_value (pc_q + 32'd1),
        .o_x       (x_val),
        .o_y       (y_val),
        .o_z       (z_val),
        .i_we      (state_q == S_WRITE && wb_reg),
        .i_wdata   (wb_value)
    );

    alu_exec u_alu (
        .i_fields (fields),
        .i_x      (x_val),
        .i_y      (y_val),
        .o_result (alu_result)
    );

    assign wb_reg   = !fields.deref[1] && !nop && !illegal;
    assign wb_value = (fields.deref == DEREF_LOAD) ? load_q : result_q;
    assign jump     = wb_reg && fields.z == REG_P;

    // Requests hold until granted
    assign o_req = (state_q == S_FETCH && i_run) || state_q == S_MEM;

    always_comb begin
        o_bus = '0;
        if (state_q == S_FETCH) begin
            o_bus.addr = pc_q & ADDR_MASK;
        end else if (state_q == S_MEM) begin
            o_bus.we = fields.deref[1];
            case (fields.deref)
                DEREF_ST_Z: begin
                    o_bus.addr  = z_val & ADDR_MASK;
                    o_bus.wdata = result_q;
                end
                DEREF_ST_RS: begin
                    o_bus.addr  = result_q & ADDR_MASK;
                    o_bus.wdata = z_val;
                end
                default: o_bus.addr = result_q & ADDR_MASK; // Load
            endcase
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH:      if (i_grant) state_d = S_FETCH_WAIT;
            S_FETCH_WAIT: if (i_rvalid) state_d = S_EXEC;
            S_EXEC: begin
                if (illegal || nop || fields.deref == DEREF_REG)
                    state_d = S_WRITE;
                else
                    state_d = S_MEM;
            end
            S_MEM: begin
                if (i_grant)
                    state_d = (fields.deref == DEREF_LOAD) ? S_MEM_WAIT : S_WRITE;
            end
            S_MEM_WAIT:   if (i_rvalid) state_d = S_WRITE;
            S_WRITE:      state_d = illegal ? S_HALT : S_FETCH;
            default:      state_d = S_HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state_q <= S_FETCH;
            pc_q    <= RESET_VECTOR;
            halt_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_EXEC && illegal)
                halt_q <= 1'b1; // Sticky until reset
            if (state_q == S_WRITE && !illegal)
                pc_q <= jump ? wb_value : pc_q + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_FETCH_WAIT && i_rvalid)
            insn_q <= i_rdata;
        if (state_q == S_EXEC)
            result_q <= alu_result;
        if (state_q == S_MEM_WAIT && i_rvalid)
            load_q <= i_rdata;
    end

    assign o_halt   = halt_q;
    assign o_retire = (state_q == S_WRITE); // One pulse per instruction

endmodule

// File: logic/mem_arbiter.sv
module mem_arbiter (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_host_req,
    input  tenyr_pkg::bus_req_t i_host_bus,
    output logic                o_host_grant,
    output logic                o_host_rvalid,
    input  logic                i_core_req,
    input  tenyr_pkg::bus_req_t i_core_bus,
    output logic                o_core_grant,
    output logic                o_core_rvalid,
    output logic                o_ram_en,
    output logic                o_ram_we,
    output tenyr_pkg::word_t    o_ram_addr,
    output tenyr_pkg::word_t    o_ram_wdata,
    input  logic                i_ram_rvalid
);

    import tenyr_pkg::*;

    logic     last_core_q; // Core won the last grant
    logic     rd_host_q;   // Owner of the read in flight
    logic     host_win, core_win;
    bus_req_t win_bus;

    // Host wins when alone or when the core went last
    assign host_win = i_host_req && (!i_core_req || last_core_q);
    assign core_win = i_core_req && !host_win;

    assign win_bus = host_win ? i_host_bus : i_core_bus;

    assign o_host_grant = host_win;
    assign o_core_grant = core_win;

    assign o_ram_en    = host_win || core_win;
    assign o_ram_we    = o_ram_en && win_bus.we;
    assign o_ram_addr  = win_bus.addr;
    assign o_ram_wdata = win_bus.wdata;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            last_core_q <= 1'b0;
            rd_host_q   <= 1'b0;
        end else begin
            if (o_ram_en)
                last_core_q <= core_win;
            if (o_ram_en && !win_bus.we)
                rd_host_q <= host_win; // RAM answers one cycle later
        end
    end

    assign o_host_rvalid = i_ram_rvalid && rd_host_q;
    assign o_core_rvalid = i_ram_rvalid && !rd_host_q;

endmodule

// File: logic/word_ram.sv
module word_ram #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              i_en,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  tenyr_pkg::word_t  i_wdata,
    output tenyr_pkg::word_t  o_rdata,
    output logic              o_rvalid
);

    import tenyr_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we)
                mem[i_addr] <= i_wdata;
            else
                o_rdata <= mem[i_addr]; // Holds until the next read
        end
    end

    // Valid trails each read by one cycle
    always_ff @(posedge clk) begin
        o_rvalid <= i_en && !i_we;
    end

endmodule

// File: logic/tenyr_system.sv
module tenyr_system #(
    parameter int ADDR_W = 10
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_run,
    input  logic                i_host_req,
    input  tenyr_pkg::bus_req_t i_host_bus,
    output logic                o_host_grant,
    output logic                o_host_rvalid,
    output tenyr_pkg::word_t    o_host_rdata,
    output logic                o_halt,
    output logic                o_retire
);

    import tenyr_pkg::*;

    logic     core_req, core_grant, core_rvalid;
    bus_req_t core_bus;
    logic     ram_en, ram_we, ram_rvalid;
    word_t    ram_addr, ram_wdata, ram_rdata;

    core_control #(
        .ADDR_W (ADDR_W)
    ) u_core (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_run    (i_run),
        .o_req    (core_req),
        .o_bus    (core_bus),
        .i_grant  (core_grant),
        .i_rvalid (core_rvalid),
        .i_rdata  (ram_rdata),
        .o_halt   (o_halt),
        .o_retire (o_retire)
    );

    mem_arbiter u_arbiter (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_host_req    (i_host_req),
        .i_host_bus    (i_host_bus),
        .o_host_grant  (o_host_grant),
        .o_host_rvalid (o_host_rvalid),
        .i_core_req    (core_req),
        .i_core_bus    (core_bus),
        .o_core_grant  (core_grant),
        .o_core_rvalid (core_rvalid),
        .o_ram_en      (ram_en),
        .o_ram_we      (ram_we),
        .o_ram_addr    (ram_addr),
        .o_ram_wdata   (ram_wdata),
        .i_ram_rvalid  (ram_rvalid)
    );

    word_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk      (clk),
        .i_en     (ram_en),
        .i_we     (ram_we),
        .i_addr   (ram_addr[ADDR_W-1:0]), // Upper address bits dropped
        .i_wdata  (ram_wdata),
        .o_rdata  (ram_rdata),
        .o_rvalid (ram_rvalid)
    );

    assign o_host_rdata = ram_rdata; // Shared read data, qualified by rvalid

endmodule

// File: bench/tenyr_system_assert.sv
module tenyr_system_assert (
    input logic clk,
    input logic reset_n,
    input logic i_a_req,
    input logic i_a_grant,
    input logic i_a_we,
    input logic i_a_rvalid,
    input logic i_b_req,
    input logic i_b_grant,
    input logic i_b_we,
    input logic i_b_rvalid,
    input logic i_halt
);

    one_grant: assert property (@(posedge clk) disable iff (reset_n)
        !(i_a_grant && i_b_grant))
        else $error("two grants in the same cycle");

    a_grant_req: assert property (@(posedge clk) disable iff (reset_n) i_a_grant |-> i_a_req)
        else $error("grant on side a without a request");

    b_grant_req: assert property (@(posedge clk) disable iff (reset_n) i_b_grant |-> i_b_req)
        else $error("grant on side b without a request");

    // Read data comes back exactly one cycle after a granted read
    a_rvalid_due: assert property (@(posedge clk) disable iff (reset_n)
        (i_a_grant && !i_a_we) |=> i_a_rvalid)
        else $error("side a read-valid missing one cycle after its read");

    a_rvalid_src: assert property (@(posedge clk) disable iff (reset_n)
        i_a_rvalid |-> $past(i_a_grant && !i_a_we))
        else $error("side a read-valid without a read one cycle earlier");

    b_rvalid_due: assert property (@(posedge clk) disable iff (reset_n)
        (i_b_grant && !i_b_we) |=> i_b_rvalid)
        else $error("side b read-valid missing one cycle after its read");

    b_rvalid_src: assert property (@(posedge clk) disable iff (reset_n)
        i_b_rvalid |-> $past(i_b_grant && !i_b_we))
        else $error("side b read-valid without a read one cycle earlier");

    halt_sticky: assert property (@(posedge clk) disable iff (reset_n) i_halt |=> i_halt)
        else $error("halt dropped before reset");

endmodule

bind mem_arbiter tenyr_system_assert arbiter_checks (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_a_req    (i_host_req),
    .i_a_grant  (o_host_grant),
    .i_a_we     (i_host_bus.we),
    .i_a_rvalid (o_host_rvalid),
    .i_b_req    (i_core_req),
    .i_b_grant  (o_core_grant),
    .i_b_we     (i_core_bus.we),
    .i_b_rvalid (o_core_rvalid),
    .i_halt     (1'b0)
);

bind core_control tenyr_system_assert core_checks (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_a_req    (o_req),
    .i_a_grant  (i_grant),
    .i_a_we     (o_bus.we),
    .i_a_rvalid (i_rvalid),
    .i_b_req    (1'b0),
    .i_b_grant  (1'b0),
    .i_b_we     (1'b0),
    .i_b_rvalid (1'b0),
    .i_halt     (o_halt)
);

// File: bench/tenyr_system_tb.sv
module tenyr_system_tb;

    import tenyr_pkg::*;

    localparam int  ADDR_W     = 10;
    localparam int  DEPTH      = 1 << ADDR_W;
    localparam int  CLK_PERIOD = 20;
    localparam int  MAX_STEPS  = 4096;
    localparam int  RESULT_AREA = 900; // Register dump area
    localparam word_t HALT_WORD = 32'hf000_0000;

    logic     clk;
    logic     reset_n;
    logic     run;
    logic     host_req;
    bus_req_t host_bus;
    logic     host_grant;
    logic     host_rvalid;
    word_t    host_rdata;
    logic     halt;
    logic     retire;

    word_t image   [DEPTH]; // Initial memory image
    word_t exp_mem [DEPTH];
    word_t act_mem [DEPTH];
    int    prog_len;
    word_t lfsr_state = 32'haaa8f95b;

    string test_name;
    int    exp_retire;
    int    act_retire;
    int    retire_cnt;
    bit    check_retire;
    bit    compare_busy = 1'b0;
    bit    run_done = 1'b0;
    time   deadline = CLK_PERIOD * 1000;
    int    check_cnt = 0;
    int    mismatch_cnt = 0;
    int    fail_cnt = 0;

    tenyr_system #(
        .ADDR_W (ADDR_W)
    ) i_tenyr_system (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_run         (run),
        .i_host_req    (host_req),
        .i_host_bus    (host_bus),
        .o_host_grant  (host_grant),
        .o_host_rvalid (host_rvalid),
        .o_host_rdata  (host_rdata),
        .o_halt        (halt),
        .o_retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset_n)
            retire_cnt <= 0;
        else if (retire)
            retire_cnt <= retire_cnt + 1;
    end

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_bits(16)) % n;
    endfunction

    function automatic int addr_of(input word_t w);
        return int'(w[ADDR_W-1:0]);
    endfunction

    function automatic word_t fill_word(input int a);
        return (word_t'(a) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic word_t enc(input int t, input int d, input int z, input int x,
                                  input int y, input int op, input int imm);
        insn_fields_t f;
        f.itype = t[0];
        f.deref = deref_t'(d);
        f.z     = reg_idx_t'(z);
        f.x     = reg_idx_t'(x);
        f.y     = reg_idx_t'(y);
        f.op    = alu_op_t'(op);
        f.imm   = imm_t'(imm);
        return {1'b0, f};
    endfunction

    // Reference ALU, X op O
    function automatic word_t ref_op(input alu_op_t op, input word_t x, input word_t o);
        word_t v;
        case (op)
            4'h0: v = x | o;
            4'h1: v = x & o;
            4'h2: v = x + o;
            4'h3: v = x * o;
            4'h5: v = (o >= 32) ? '0 : x << o;
            4'h6: v = ($signed(x) < $signed(o)) ? '1 : '0;
            4'h7: v = (x == o) ? '1 : '0;
            4'h8: v = ($signed(x) > $signed(o)) ? '1 : '0;
            4'h9: v = x & ~o;
            4'ha: v = x ^ o;
            4'hb: v = x - o;
            4'hc: v = x ^ ~o;
            4'hd: v = (o >= 32) ? '0 : x >> o;
            4'he: v = (x != o) ? '1 : '0;
            default: v = '0; // Reserved
        endcase
        return v;
    endfunction

    // Instruction-set model on exp_mem, returns the retire count
    function automatic int run_model();
        word_t r [16];
        word_t pc, insn, x, y, z, imm, res, wb;
        insn_fields_t f;
        int retired;
        bit halted;
        pc = RESET_VECTOR;
        retired = 0;
        halted = 1'b0;
        wb = '0;
        foreach (r[i]) r[i] = '0;
        while (!halted && retired < MAX_STEPS) begin
            insn = exp_mem[addr_of(pc)];
            retired++;
            if (insn[31:28] == 4'hf) begin
                halted = 1'b1;
            end else if (insn[31]) begin
                pc = pc + 1; // No-op
            end else begin
                f = insn_fields_t'(insn[30:0]);
                r[REG_P] = pc + 1;
                x = r[f.x];
                y = r[f.y];
                z = r[f.z];
                imm = {{20{f.imm[11]}}, f.imm};
                res = f.itype ? ref_op(f.op, x, imm) + y : ref_op(f.op, x, y) + imm;
                pc = pc + 1;
                case (f.deref)
                    2'b00: wb = res;
                    2'b01: wb = exp_mem[addr_of(res)];
                    2'b10: exp_mem[addr_of(z)] = res;
                    default: exp_mem[addr_of(res)] = z;
                endcase
                if (!f.deref[1]) begin
                    if (f.z == REG_P)
                        pc = wb; // Jump
                    else if (f.z != 0)
                        r[f.z] = wb;
                end
            end
        end
        if (!halted) begin
            $display("%s: reference model ran past %0d steps without a halt", test_name,
                     MAX_STEPS);
            fail_cnt++;
        end
        return retired;
    endfunction

    function automatic time cycle_budget(input int instrs);
        return CLK_PERIOD * (200 + 5 * DEPTH + 8 * instrs); // Load, readback, run
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        check_cnt++;
        if (actual !== expected) begin
            mismatch_cnt++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        check_cnt++;
        if (actual !== expected) begin
            mismatch_cnt++;
            $display("mismatch %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt,
                 fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    task automatic emit(input word_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic begin_image();
        for (int a = 0; a < DEPTH; a++)
            image[a] = fill_word(a);
        prog_len = 0;
        emit(enc(1, DEREF_REG, 12, 0, 0, 0, 512)); // r12 and r13 hold data bases
        emit(enc(1, DEREF_REG, 13, 0, 0, 0, 768));
    endtask

    task automatic end_image();
        for (int r = 0; r < 16; r++)
            emit(enc(1, DEREF_ST_RS, r, 0, 0, 0, RESULT_AREA + r));
        emit(HALT_WORD);
    endtask

    function automatic word_t rand_alu(input int z_limit, input int op);
        int t, z, x, y, imm;
        t = rand_bits(1);
        z = rand_below(z_limit);
        x = rand_below(16);
        y = rand_below(16);
        imm = rand_bits(12);
        return enc(t, DEREF_REG, z, x, y, op, imm);
    endfunction

    // Data accesses stay in 512..895, code is never overwritten
    function automatic word_t rand_mixed(input int kind);
        int t, zl, za, x, y, op, imm, off, base, lbase;
        word_t w;
        t = rand_bits(1);
        zl = rand_below(12);
        za = rand_below(16);
        x = rand_below(16);
        y = rand_below(16);
        op = rand_bits(4);
        imm = rand_bits(12);
        off = rand_below(128);
        base = 12 + rand_below(2);
        lbase = rand_below(3);
        lbase = (lbase == 0) ? 0 : 11 + lbase; // r0 reads code, r12 or r13 data
        case (kind)
            0: w = enc(t, DEREF_REG, zl, x, y, op, imm);
            1: w = enc(1, DEREF_LOAD, zl, 0, lbase, 0, off);
            2: w = enc(t, DEREF_ST_Z, base, x, y, op, imm);
            default: w = enc(1, DEREF_ST_RS, za, 0, base, 0, off);
        endcase
        return w;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_n = 1'b1;
        run = 1'b0;
        host_req = 1'b0;
        host_bus = '0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b0;
    endtask

    task automatic host_write(input word_t addr, input word_t data);
        @(posedge clk);
        #2;
        host_req = 1'b1;
        host_bus.we = 1'b1;
        host_bus.addr = addr;
        host_bus.wdata = data;
        @(posedge clk);
        while (!host_grant) @(posedge clk);
        #2;
        host_req = 1'b0;
        host_bus.we = 1'b0;
    endtask

    task automatic host_read(input word_t addr, output word_t data);
        @(posedge clk);
        #2;
        host_req = 1'b1;
        host_bus.we = 1'b0;
        host_bus.addr = addr;
        host_bus.wdata = '0;
        @(posedge clk);
        while (!host_grant) @(posedge clk);
        #2;
        host_req = 1'b0;
        @(posedge clk);
        if (!host_rvalid) begin
            $display("%s: host read of word %0d got no read-valid one cycle after the grant",
                     test_name, addr);
            fail_cnt++;
        end
        data = host_rdata;
    endtask

    task automatic load_image();
        for (int a = 0; a < DEPTH; a++)
            host_write(word_t'(a), image[a]);
    endtask

    task automatic read_back();
        word_t d;
        for (int a = 0; a < DEPTH; a++) begin
            host_read(word_t'(a), d);
            act_mem[a] = d;
        end
    endtask

    task automatic run_core();
        @(posedge clk);
        if (halt) begin
            $display("%s: halt was already set before the core started", test_name);
            fail_cnt++;
        end
        #2;
        run = 1'b1;
        @(posedge clk);
        while (!halt) @(posedge clk);
        repeat (4) @(posedge clk); // Halting word still retires
        #2;
        run = 1'b0;
        repeat (16) @(posedge clk); // Memory must stay still after halt
    endtask

    task automatic host_reads_during_run();
        int a;
        word_t d;
        a = 0;
        while (!halt) begin
            host_read(word_t'(a), d);
            check_word($sformatf("%s, host read of word %0d", test_name, a), image[a], d);
            a = (a + 1) % prog_len;
        end
    endtask

    task automatic compare_images();
        compare_busy = 1'b1;
        wait (!compare_busy);
    endtask

    initial begin : compare
        forever begin
            wait (compare_busy);
            for (int a = 0; a < DEPTH; a++)
                check_word($sformatf("%s, word %0d", test_name, a), exp_mem[a], act_mem[a]);
            if (check_retire)
                check_count({test_name, ", retire count"}, exp_retire, act_retire);
            compare_busy = 1'b0;
        end
    end

    task automatic test_host_memory();
        test_name = "host write and read";
        deadline = $time + cycle_budget(0);
        for (int a = 0; a < DEPTH; a++)
            image[a] = rand_bits(32);
        exp_mem = image; // Memory alone is the model
        apply_reset();
        load_image();
        read_back();
        check_retire = 1'b0;
        compare_images();
    endtask

    task automatic run_program_test(input string name, input bit with_host);
        test_name = name;
        exp_mem = image;
        exp_retire = run_model();
        deadline = $time + cycle_budget(exp_retire);
        apply_reset();
        load_image();
        if (with_host) begin
            fork
                run_core();
                host_reads_during_run();
            join
        end else begin
            run_core();
        end
        read_back();
        act_retire = retire_cnt;
        check_retire = 1'b1;
        compare_images();
    endtask

    task automatic build_jump_program();
        begin_image();
        for (int i = 0; i < 8; i++)
            emit(rand_alu(12, int'(rand_bits(4))));
        emit(enc(1, DEREF_REG, REG_P, REG_P, 0, 2, 6)); // P <- P + 6
        for (int k = 0; k < 6; k++)
            emit(enc(1, DEREF_ST_RS, k + 1, 0, 12, 0, k)); // Skipped
        for (int k = 0; k < 6; k++)
            emit(enc(1, DEREF_ST_RS, k + 1, 0, 13, 0, k));
        emit(enc(0, DEREF_REG, REG_P, REG_P, 0, 0, 2)); // P <- (P | r0) + 2
        emit(enc(1, DEREF_ST_RS, 1, 0, 12, 0, 8));
        emit(enc(1, DEREF_ST_RS, 2, 0, 12, 0, 9));
        end_image();
    endtask

    task automatic build_halt_program();
        word_t w;
        begin_image();
        for (int i = 0; i < 12; i++)
            emit(rand_mixed(i % 4));
        w = rand_bits(28);
        w[31:28] = 4'h8 + 4'(rand_below(7)); // No-op, never the halt nibble
        emit(w);
        emit(rand_mixed(3));
        w = rand_bits(28);
        w[31:28] = 4'hf;
        emit(w);
        for (int k = 0; k < 4; k++)
            emit(enc(1, DEREF_ST_RS, k + 1, 0, 12, 0, k)); // Past the halt
        end_image();
    endtask

    initial begin : main
        reset_n = 1'b1;
        run = 1'b0;
        host_req = 1'b0;
        host_bus = '0;
        check_retire = 1'b0;

        test_host_memory();

        begin_image();
        for (int i = 0; i < 48; i++)
            emit(rand_alu(15, i % 16)); // Every op, z never P
        end_image();
        run_program_test("alu ops", 1'b0);

        begin_image();
        for (int i = 0; i < 48; i++)
            emit(rand_mixed(i % 4));
        end_image();
        run_program_test("deref modes", 1'b0);

        build_jump_program();
        run_program_test("jump through p", 1'b0);

        build_halt_program();
        run_program_test("illegal word halt", 1'b0);

        begin_image();
        for (int i = 0; i < 64; i++)
            emit(rand_mixed(i % 4));
        end_image();
        run_program_test("host reads during run", 1'b1);

        run_done = 1'b1;
        report_and_finish();
    end

    initial begin : watchdog
        while (!run_done && $time < deadline)
            @(posedge clk);
        if (!run_done) begin
            $display("timeout: %s did not finish within its cycle budget", test_name);
            fail_cnt++;
            report_and_finish();
        end
    end

endmodule

// File: tenyr_system.f
logic/tenyr_pkg.sv
logic/insn_decode.sv
logic/reg_file.sv
logic/alu_exec.sv
logic/core_control.sv
logic/mem_arbiter.sv
logic/word_ram.sv
logic/tenyr_system.sv
bench/tenyr_system_assert.sv
bench/tenyr_system_tb.sv
